// File: design/uartHubPkg.sv
////////////////////////////////////////////////////////////
// UART receive hub shared definitions
// Sizes, AXI4-Lite channel bundles and FSM encodings
////////////////////////////////////////////////////////////
`default_nettype none

package uartHubPkg;

        localparam int NUM_CHANNELS   = 4;            // Serial channels
        localparam int DATA_BITS      = 8;            // Bits per character
        localparam int FIFO_ADDR_BITS = 4;            // 16 entries per FIFO
        localparam int OVERSAMPLE     = 16;           // Ticks per bit
        localparam int BAUD_DIV       = 4;            // Clocks per tick
        localparam int AXI_ADDR_BITS  = 8;
        localparam int AXI_DATA_BITS  = 32;
        localparam logic [AXI_ADDR_BITS-1:0] CTRL_ADDR = 8'h40;

        ////////////////////////////////////////////////////////////
        // Encodings
        ////////////////////////////////////////////////////////////
        typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxState_e;
        typedef enum logic [1:0] {AXI_IDLE, POP_WAIT, READ_RESP, WRITE_RESP} axiState_e;
        typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10} axiResp_e;

        ////////////////////////////////////////////////////////////
        // Bundles
        ////////////////////////////////////////////////////////////
        typedef struct packed {
                logic                 valid;          // One cycle per good frame
                logic [DATA_BITS-1:0] data;
        } rxByte_t;

        // Bit order matches the status register layout
        typedef struct packed {
                logic full;
                logic halfFull;
                logic empty;
        } fifoStatus_t;

        typedef struct packed {
                logic                       awvalid;
                logic [AXI_ADDR_BITS-1:0]   awaddr;
                logic                       wvalid;
                logic [AXI_DATA_BITS-1:0]   wdata;
                logic [AXI_DATA_BITS/8-1:0] wstrb;
                logic                       bready;
                logic                       arvalid;
                logic [AXI_ADDR_BITS-1:0]   araddr;
                logic                       rready;
        } axiLiteReq_t;

        typedef struct packed {
                logic                     awready;
                logic                     wready;
                logic                     bvalid;
                axiResp_e                 bresp;
                logic                     arready;
                logic                     rvalid;
                logic [AXI_DATA_BITS-1:0] rdata;
                axiResp_e                 rresp;
        } axiLiteRsp_t;

endpackage

`default_nettype wire

// File: design/baudGen.sv
////////////////////////////////////////////////////////////
// Baud tick generator
// One-cycle 16x oversample tick shared by all receivers
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module baudGen (
        input  logic clk,
        input  logic rst,
        output logic tick
);
        import uartHubPkg::*;

        localparam int DIV_BITS = $clog2(BAUD_DIV);
        localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(BAUD_DIV - 1);

        logic [DIV_BITS-1:0] divCount;                // Clocks since last tick

        always_ff @(posedge clk) begin
                if (rst) begin
                        divCount <= '0;
                        tick     <= 1'b0;
                end else begin
                        tick <= (divCount == DIV_LAST);   // Pulse on wrap
                        if (divCount == DIV_LAST)
                                divCount <= '0;
                        else
                                divCount <= divCount + 1'b1;
                end
        end

endmodule

`default_nettype wire

// File: design/uartRx.sv
////////////////////////////////////////////////////////////
// UART frame receiver
// 16x oversampled 8N1 input, one byte out per good frame
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uartRx (
        input  logic                clk,
        input  logic                rst,
        input  logic                tick,
        input  logic                rx,
        output uartHubPkg::rxByte_t rxByte
);
        import uartHubPkg::*;

        localparam int TICK_BITS = $clog2(OVERSAMPLE);
        localparam int BIT_BITS  = $clog2(DATA_BITS);
        localparam logic [TICK_BITS-1:0] MID_TICK  = TICK_BITS'(OVERSAMPLE/2 - 1);
        localparam logic [TICK_BITS-1:0] LAST_TICK = TICK_BITS'(OVERSAMPLE - 1);
        localparam logic [BIT_BITS-1:0]  LAST_BIT  = BIT_BITS'(DATA_BITS - 1);

        logic [1:0]           rxSync;                 // Two-flop synchronizer
        logic                 rxLast;                 // Previous synced level
        rxState_e             state;
        logic [TICK_BITS-1:0] tickCount;
        logic [BIT_BITS-1:0]  bitCount;
        logic [DATA_BITS-1:0] shiftReg;
        logic                 rxValid;
        logic                 bitDone;

        assign bitDone = tick && (tickCount == LAST_TICK);   // Middle of a bit

        // Line idles high
        always_ff @(posedge clk) begin
                if (rst) begin
                        rxSync <= 2'b11;
                        rxLast <= 1'b1;
                end else begin
                        rxSync <= {rxSync[0], rx};
                        rxLast <= rxSync[1];
                end
        end

        ////////////////////////////////////////////////////////////
        // Frame FSM
        ////////////////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (rst) begin
                        state     <= RX_IDLE;
                        tickCount <= '0;
                        bitCount  <= '0;
                        rxValid   <= 1'b0;
                end else begin
                        rxValid <= 1'b0;
                        if (tick && state != RX_IDLE)
                                tickCount <= tickCount + 1'b1;
                        case (state)
                        RX_IDLE: begin
                                if (rxLast && !rxSync[1]) begin   // Falling start edge
                                        state     <= RX_START;
                                        tickCount <= '0;
                                end
                        end
                        RX_START: begin
                                if (tick && tickCount == MID_TICK) begin
                                        tickCount <= '0;
                                        bitCount  <= '0;
                                        state     <= rxSync[1] ? RX_IDLE : RX_DATA; // Glitch check
                                end
                        end
                        RX_DATA: begin
                                if (bitDone) begin
                                        bitCount <= bitCount + 1'b1;
                                        if (bitCount == LAST_BIT)
                                                state <= RX_STOP;
                                end
                        end
                        RX_STOP: begin
                                if (bitDone) begin
                                        rxValid <= rxSync[1];     // Bad stop bit drops the byte
                                        state   <= RX_IDLE;
                                end
                        end
                        default: state <= RX_IDLE;
                        endcase
                end
        end

        // LSB arrives first
        always_ff @(posedge clk) begin
                if (state == RX_DATA && bitDone)
                        shiftReg <= {rxSync[1], shiftReg[DATA_BITS-1:1]};
        end

        assign rxByte = {rxValid, shiftReg};

endmodule

`default_nettype wire

// File: design/rxFifo.sv
////////////////////////////////////////////////////////////
// Receive FIFO
// Empty, half-full and full flags, registered pop data
// BIST mode freezes all state
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rxFifo #(
        parameter int ADDR_BITS = uartHubPkg::FIFO_ADDR_BITS
) (
        input  logic                             clk,
        input  logic                             rst,
        input  uartHubPkg::rxByte_t              wrByte,
        input  logic                             pop,
        input  logic                             bistMode,
        output uartHubPkg::fifoStatus_t          status,
        output logic [uartHubPkg::DATA_BITS-1:0] dataOut
);
        import uartHubPkg::*;

        localparam int DEPTH = 2 ** ADDR_BITS;
        localparam logic [ADDR_BITS:0] FULL_COUNT = (ADDR_BITS+1)'(DEPTH);
        localparam logic [ADDR_BITS:0] HALF_COUNT = (ADDR_BITS+1)'(DEPTH/2);

        logic [DATA_BITS-1:0] mem [DEPTH];            // Circular buffer
        logic [ADDR_BITS-1:0] rdPtr;
        logic [ADDR_BITS-1:0] wrPtr;
        logic [ADDR_BITS:0]   count;                  // Entries held
        logic [ADDR_BITS:0]   countNext;
        logic                 doPush;
        logic                 doPop;

        assign doPush = wrByte.valid && !bistMode && (count != FULL_COUNT); // Drop when full
        assign doPop  = pop && !bistMode && (count != '0);

        // Push and pop together leave the count alone
        always_comb begin
                countNext = count;
                if (doPush && !doPop)
                        countNext = count + 1'b1;
                else if (doPop && !doPush)
                        countNext = count - 1'b1;
        end

        ////////////////////////////////////////////////////////////
        // Pointers and flags
        ////////////////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (rst) begin
                        rdPtr  <= '0;
                        wrPtr  <= '0;
                        count  <= '0;
                        status <= '{full: 1'b0, halfFull: 1'b0, empty: 1'b1};
                end else begin
                        if (doPush)
                                wrPtr <= wrPtr + 1'b1;
                        if (doPop)
                                rdPtr <= rdPtr + 1'b1;
                        count           <= countNext;
                        status.empty    <= (countNext == '0);
                        status.halfFull <= (countNext >= HALF_COUNT);
                        status.full     <= (countNext == FULL_COUNT);
                end
        end

        // Storage and pop register
        always_ff @(posedge clk) begin
                if (doPush)
                        mem[wrPtr] <= wrByte.data;
                if (doPop)
                        dataOut <= mem[rdPtr];        // Held when empty
        end

endmodule

`default_nettype wire

// File: design/axiLiteRegs.sv
////////////////////////////////////////////////////////////
// AXI4-Lite register block
// Per-channel data and status registers, BIST control bit
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axiLiteRegs (
        input  logic                                                   clk,
        input  logic                                                   rst,
        input  uartHubPkg::axiLiteReq_t                                axiReq,
        output uartHubPkg::axiLiteRsp_t                                axiRsp,
        input  uartHubPkg::fifoStatus_t [uartHubPkg::NUM_CHANNELS-1:0] status,
        input  logic [uartHubPkg::NUM_CHANNELS-1:0][uartHubPkg::DATA_BITS-1:0] fifoData,
        output logic [uartHubPkg::NUM_CHANNELS-1:0]                    pop,
        output logic                                                   bistMode
);
        import uartHubPkg::*;

        localparam int CH_BITS = $clog2(NUM_CHANNELS);

        axiState_e                state;
        logic                     wrFire;             // AW and W accepted
        logic                     rdFire;             // AR accepted
        logic [CH_BITS-1:0]       arChan;
        logic                     arInChan;           // Address hits a channel register
        logic [CH_BITS-1:0]       rdChan;
        logic                     rdFromFifo;         // Return popped byte
        logic [AXI_DATA_BITS-1:0] rdataReg;
        axiResp_e                 bresp;
        axiResp_e                 rresp;

        ////////////////////////////////////////////////////////////
        // Handshake and decode
        ////////////////////////////////////////////////////////////
        assign wrFire   = (state == AXI_IDLE) && axiReq.awvalid && axiReq.wvalid;
        assign rdFire   = (state == AXI_IDLE) && axiReq.arvalid && !wrFire; // Write first
        assign arChan   = axiReq.araddr[3 +: CH_BITS];             // 8 bytes per channel
        assign arInChan = (axiReq.araddr < AXI_ADDR_BITS'(NUM_CHANNELS * 8)) &&
                          (axiReq.araddr[1:0] == 2'b00);

        always_comb begin
                axiRsp         = '0;
                axiRsp.awready = wrFire;
                axiRsp.wready  = wrFire;
                axiRsp.bvalid  = (state == WRITE_RESP);
                axiRsp.bresp   = bresp;
                axiRsp.arready = rdFire;
                axiRsp.rvalid  = (state == READ_RESP);
                axiRsp.rdata   = rdFromFifo ? AXI_DATA_BITS'(fifoData[rdChan]) : rdataReg;
                axiRsp.rresp   = rresp;
        end

        ////////////////////////////////////////////////////////////
        // Response FSM
        ////////////////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (rst) begin
                        state      <= AXI_IDLE;
                        pop        <= '0;
                        bistMode   <= 1'b0;
                        rdFromFifo <= 1'b0;
                end else begin
                        pop <= '0;                    // Single-cycle strobe
                        case (state)
                        AXI_IDLE: begin
                                if (wrFire) begin
                                        state <= WRITE_RESP;
                                        bresp <= SLVERR;  // Only control is writable
                                        if (axiReq.awaddr == CTRL_ADDR) begin
                                                bresp <= OKAY;
                                                if (axiReq.wstrb[0])
                                                        bistMode <= axiReq.wdata[0];
                                        end
                                end else if (rdFire) begin
                                        rdChan     <= arChan;
                                        rresp      <= OKAY;
                                        rdataReg   <= '0;
                                        rdFromFifo <= 1'b0;
                                        state      <= READ_RESP;
                                        if (arInChan && !axiReq.araddr[2]) begin // Data
                                                state <= POP_WAIT;
                                                if (!status[arChan].empty) begin
                                                        pop[arChan] <= 1'b1;
                                                        rdFromFifo  <= 1'b1;
                                                end  // Empty reads zero
                                        end else if (arInChan) begin      // Status
                                                rdataReg <= AXI_DATA_BITS'(status[arChan]);
                                        end else if (axiReq.araddr == CTRL_ADDR) begin
                                                rdataReg <= AXI_DATA_BITS'(bistMode);
                                        end else begin
                                                rresp <= SLVERR;
                                        end
                                end
                        end
                        POP_WAIT:   state <= READ_RESP;   // FIFO loads dataOut
                        READ_RESP:  if (axiReq.rready) state <= AXI_IDLE;
                        WRITE_RESP: if (axiReq.bready) state <= AXI_IDLE;
                        default:    state <= AXI_IDLE;
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: design/uartRxHub.sv
////////////////////////////////////////////////////////////
// Four-channel UART receive hub
// Receivers and FIFOs per channel, drained over AXI4-Lite
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uartRxHub (
        input  logic                                clk,
        input  logic                                rst,
        input  logic [uartHubPkg::NUM_CHANNELS-1:0] rx,
        input  uartHubPkg::axiLiteReq_t             axiReq,
        output uartHubPkg::axiLiteRsp_t             axiRsp
);
        import uartHubPkg::*;

        logic                                   tick;         // Shared 16x tick
        rxByte_t                                rxByte [NUM_CHANNELS];
        fifoStatus_t [NUM_CHANNELS-1:0]         fifoStatus;
        logic [NUM_CHANNELS-1:0][DATA_BITS-1:0] fifoData;
        logic [NUM_CHANNELS-1:0]                pop;
        logic                                   bistMode;     // Freezes every FIFO

        baudGen i_baudGen (.clk(clk), .rst(rst), .tick(tick));

        ////////////////////////////////////////////////////////////
        // Per-channel receive path
        ////////////////////////////////////////////////////////////
        for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : gChannel
                uartRx i_uartRx (
                        .clk(clk), .rst(rst), .tick(tick),
                        .rx(rx[ch]), .rxByte(rxByte[ch])
                );

                rxFifo #(.ADDR_BITS(FIFO_ADDR_BITS)) i_rxFifo (
                        .clk(clk), .rst(rst),
                        .wrByte(rxByte[ch]), .pop(pop[ch]), .bistMode(bistMode),
                        .status(fifoStatus[ch]), .dataOut(fifoData[ch])
                );
        end

        axiLiteRegs i_axiLiteRegs (
                .clk(clk), .rst(rst),
                .axiReq(axiReq), .axiRsp(axiRsp),
                .status(fifoStatus), .fifoData(fifoData),
                .pop(pop), .bistMode(bistMode)
        );

endmodule

`default_nettype wire

// File: verification/uartRxHubTb.sv
////////////////////////////////////////////////////////////
// UART receive hub testbench
// Replays a trace of serial frames and AXI4-Lite accesses
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uartRxHubTb;
        import uartHubPkg::*;

        localparam int    BIT_CYCLES     = OVERSAMPLE * BAUD_DIV;   // 64 clocks per bit
        localparam int    CYCLES_PER_CMD = 1000;                    // One frame plus AXI traffic
        localparam int    CH_BITS        = $clog2(NUM_CHANNELS);
        localparam string TRACE_FILE     = "verification/rxTrace.txt";

        logic                    clk;
        logic                    rst;
        logic [NUM_CHANNELS-1:0] rx;
        axiLiteReq_t             axiReq;
        axiLiteRsp_t             axiRsp;
        integer                  seed;                // Idle gap generator
        int                      cycles = 0;
        int                      cycleLimit;
        int                      cmdCount;
        int                      executed;

        uartRxHub i_uartRxHub (.clk(clk), .rst(rst), .rx(rx), .axiReq(axiReq), .axiRsp(axiRsp));

        always #5 clk = ~clk;                         // 10 ns period

        ////////////////////////////////////////////////////////////
        // Watchdog
        ////////////////////////////////////////////////////////////
        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycleLimit > 0 && cycles >= cycleLimit) begin
                        $display("Timeout: trace did not finish within %0d cycles", cycleLimit);
                        stopRun();
                end
        end

        task automatic stopRun();
                $display("** FAIL **");
                $fatal(1, "Simulation stopped on error");
        endtask

        // Compares, one per result type
        task automatic checkByte(input logic [DATA_BITS-1:0] got, input logic [DATA_BITS-1:0] exp);
                if (got !== exp) begin
                        $display("FAILED at %0d ns: read data %02h, expected %02h", $time, got, exp);
                        stopRun();
                end
        endtask

        task automatic checkStatus(input fifoStatus_t got, input fifoStatus_t exp);
                if (got !== exp) begin
                        $display("FAILED at %0d ns: status full/halfFull/empty %b%b%b, expected %b%b%b",
                                 $time, got.full, got.halfFull, got.empty,
                                 exp.full, exp.halfFull, exp.empty);
                        stopRun();
                end
        endtask

        task automatic checkResp(input axiResp_e got, input axiResp_e exp);
                if (got !== exp) begin
                        $display("FAILED at %0d ns: response %s, expected %s",
                                 $time, got.name(), exp.name());
                        stopRun();
                end
        endtask

        ////////////////////////////////////////////////////////////
        // Line driver and AXI master
        ////////////////////////////////////////////////////////////
        task automatic sendFrame(input logic [CH_BITS-1:0] ch, input logic [DATA_BITS-1:0] data,
                                 input logic stopBit);
                logic [DATA_BITS+1:0] frame;
                int                   gap;
                frame = {stopBit, data, 1'b0};        // Start bit goes out first
                @(negedge clk);
                repeat (DATA_BITS + 2) begin
                        rx[ch] = frame[0];
                        frame  = frame >> 1;
                        repeat (BIT_CYCLES) @(negedge clk);
                end
                rx[ch] = 1'b1;                        // Back to idle
                gap = 16 + ($random(seed) & 63);
                repeat (gap) @(negedge clk);
        endtask

        task automatic axiWrite(input logic [AXI_ADDR_BITS-1:0] addr,
                                input logic [AXI_DATA_BITS-1:0] data, output axiResp_e resp);
                @(negedge clk);
                axiReq.awvalid = 1'b1;
                axiReq.awaddr  = addr;
                axiReq.wvalid  = 1'b1;
                axiReq.wdata   = data;
                axiReq.wstrb   = '1;
                axiReq.bready  = 1'b1;
                #1;
                while (!(axiRsp.awready && axiRsp.wready)) begin
                        @(negedge clk);
                        #1;
                end
                @(negedge clk);                       // Accepted on the edge just passed
                axiReq.awvalid = 1'b0;
                axiReq.wvalid  = 1'b0;
                while (!axiRsp.bvalid)
                        @(negedge clk);
                resp = axiRsp.bresp;
                @(negedge clk);
                axiReq.bready = 1'b0;
        endtask

        task automatic axiRead(input logic [AXI_ADDR_BITS-1:0] addr,
                               output logic [AXI_DATA_BITS-1:0] data, output axiResp_e resp);
                @(negedge clk);
                axiReq.arvalid = 1'b1;
                axiReq.araddr  = addr;
                axiReq.rready  = 1'b1;
                #1;
                while (!axiRsp.arready) begin
                        @(negedge clk);
                        #1;
                end
                @(negedge clk);
                axiReq.arvalid = 1'b0;
                while (!axiRsp.rvalid)                // Data reads take one extra cycle
                        @(negedge clk);
                data = axiRsp.rdata;
                resp = axiRsp.rresp;
                @(negedge clk);
                axiReq.rready = 1'b0;
        endtask

        ////////////////////////////////////////////////////////////
        // Trace handling
        ////////////////////////////////////////////////////////////
        task automatic countCommands(output int count);
                int             fd;
                logic [8*8-1:0] tok;
                logic [1023:0]  rest;
                count = 0;
                fd = $fopen(TRACE_FILE, "r");
                if (fd == 0) begin
                        $display("Could not open the trace file %s", TRACE_FILE);
                        stopRun();
                end else begin
                        while ($fscanf(fd, "%s", tok) == 1) begin
                                if (tok[7:0] == "#")
                                        void'($fgets(rest, fd));     // Skip comment
                                else if (tok[7:0] inside {"U", "B", "W", "R", "S"})
                                        count++;
                        end
                        $fclose(fd);
                end
        endtask

        task automatic runTrace(output int done);
                int                       fd;
                logic [8*8-1:0]           tok;
                logic [7:0]               cmd;
                logic [1023:0]            rest;
                logic [AXI_DATA_BITS-1:0] a;
                logic [AXI_DATA_BITS-1:0] b;
                logic [AXI_DATA_BITS-1:0] c;
                logic [AXI_DATA_BITS-1:0] rdata;
                axiResp_e                 resp;
                done = 0;
                fd = $fopen(TRACE_FILE, "r");
                while ($fscanf(fd, "%s", tok) == 1) begin
                        cmd = tok[7:0];
                        if (cmd == "#") begin
                                void'($fgets(rest, fd));
                        end else begin
                                done++;
                                case (cmd)
                                "U", "B": begin           // Good or bad stop bit
                                        void'($fscanf(fd, "%h %h", a, b));
                                        sendFrame(a[CH_BITS-1:0], b[DATA_BITS-1:0], cmd == "U");
                                end
                                "W": begin                // Only control is writable
                                        void'($fscanf(fd, "%h %h", a, b));
                                        axiWrite(a[AXI_ADDR_BITS-1:0], b, resp);
                                        checkResp(resp, (a[AXI_ADDR_BITS-1:0] == CTRL_ADDR) ?
                                                  OKAY : SLVERR);
                                end
                                "R": begin
                                        void'($fscanf(fd, "%h %h %h", a, b, c));
                                        axiRead(a[AXI_ADDR_BITS-1:0], rdata, resp);
                                        checkByte(rdata[DATA_BITS-1:0], b[DATA_BITS-1:0]);
                                        checkResp(resp, axiResp_e'(c[1:0]));
                                end
                                "S": begin                // Status register at ch*8+4
                                        void'($fscanf(fd, "%h %h", a, b));
                                        axiRead(AXI_ADDR_BITS'(a * 8 + 4), rdata, resp);
                                        checkStatus(fifoStatus_t'(rdata[2:0]), fifoStatus_t'(b[2:0]));
                                        checkResp(resp, OKAY);
                                end
                                default: begin
                                        $display("Unknown command '%s' in the trace", tok);
                                        stopRun();
                                end
                                endcase
                        end
                end
                $fclose(fd);
        endtask

        initial begin
                clk        = 1'b0;
                rst        = 1'b1;
                rx         = '1;                      // Lines idle high
                axiReq     = '0;
                seed       = 32'hc184b315;
                cycleLimit = 0;
                countCommands(cmdCount);
                cycleLimit = (cmdCount + 1) * CYCLES_PER_CMD;
                repeat (3) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;
                runTrace(executed);
                if (executed == 0) begin
                        $display("The trace held no commands");
                        stopRun();
                end else begin
                        $display("** PASS **");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// File: verification/rxTrace.txt
# Fields in hex. U/B ch byte = good/bad-stop frame, W addr data = write
# R addr expData expResp = read, S ch expStatus = {full,halfFull,empty}
S 0 1
S 3 1
U 0 5a
U 1 c3
U 0 a5
U 2 3c
S 0 0
R 08 c3 0 # channels drain independently
R 00 5a 0
R 00 a5 0
R 10 3c 0
S 0 1
R 00 00 0 # empty read returns zero
S 0 1
B 1 77 # low stop bit adds nothing
S 1 1
R 08 00 0
U 3 10 U 3 11 U 3 12 U 3 13
U 3 14 U 3 15 U 3 16 U 3 17
S 3 2
U 3 18 U 3 19 U 3 1a U 3 1b
U 3 1c U 3 1d U 3 1e U 3 1f
S 3 6
U 3 20 # dropped while full
S 3 6
R 18 10 0 R 18 11 0 R 18 12 0 R 18 13 0
R 18 14 0 R 18 15 0 R 18 16 0 R 18 17 0
S 3 2
R 18 18 0 R 18 19 0 R 18 1a 0 R 18 1b 0
R 18 1c 0 R 18 1d 0 R 18 1e 0 R 18 1f 0
S 3 1
U 2 81
W 40 1 # BIST freezes all FIFOs
R 40 01 0
U 2 82
S 2 0
R 10 3c 0 # pop ignored, old output held
S 2 0
W 40 0
R 40 00 0
R 10 81 0
S 2 1
R 50 00 2
R 06 00 2
W 0c ff

// File: sources.f
design/uartHubPkg.sv
design/baudGen.sv
design/uartRx.sv
design/rxFifo.sv
design/axiLiteRegs.sv
design/uartRxHub.sv
verification/uartRxHubTb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --timing --timescale 1ns/1ps
TOP   = uartRxHubTb
FLIST = sources.f
LOG   = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qxF "** PASS **" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
